// File: mem_subsys_top.f
memreq_pkg.sv
request_unit.sv
wb_manager.sv
wb_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 en_i,
    input  wire memreq_pkg::cpu_req_t cpu_req_i,
    input  wire logic [31:0]          instruction_address_i,
    output logic [31:0]               instruction_o,
    output logic [31:0]               data_read_o,
    output logic                      i_hit_o,
    output logic                      d_hit_o
);

    import memreq_pkg::*;

    bus_cmd_t    cmd;        // request unit to manager
    logic        busy;
    logic [31:0] bus_rdata;
    wb_m2s_t     wb_m2s;
    wb_s2m_t     wb_s2m;

    request_unit u_req (
        .en_i                  (en_i),
        .clk                   (clk),
        .rst                   (rst),
        .cpu_req_i             (cpu_req_i),
        .instruction_address_i (instruction_address_i),
        .busy_i                (busy),
        .bus_rdata_i           (bus_rdata),
        .cmd_o                 (cmd),
        .instruction_o         (instruction_o),
        .data_read_o           (data_read_o),
        .i_hit_o               (i_hit_o),
        .d_hit_o               (d_hit_o)
    );

    wb_manager u_wbm (
        .clk     (clk),
        .rst     (rst),
        .cmd_i   (cmd),
        .busy_o  (busy),
        .rdata_o (bus_rdata),
        .wb_o    (wb_m2s),
        .wb_i    (wb_s2m)
    );

    wb_sram u_sram (
        .clk  (clk),
        .rst  (rst),
        .wb_i (wb_m2s),
        .wb_o (wb_s2m)
    );

endmodule

`default_nettype wire

// File: memreq_pkg.sv
`default_nettype none

package memreq_pkg;

    // every cpu address is shifted into the sram window on the bus
    localparam logic [31:0] BUS_BASE = 32'h3300_0000;

    localparam int MEM_WORDS = 256;
    localparam int MEM_AW = $clog2(MEM_WORDS);           // word index width, 8
    localparam int WAIT_STATES = 2;                      // sram cycles before ack
    localparam int WAIT_CW = $clog2(WAIT_STATES + 1);
    localparam logic [3:0] SEL_WORD = 4'hF;              // full word stores only

    // data side request from the cpu
    typedef struct packed {
        logic        memread;
        logic        memwrite;
        logic [31:0] data_address;
        logic [31:0] data_to_write;
    } cpu_req_t;

    // request unit to bus manager, read/write are single cycle strobes
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } bus_cmd_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_READ,
        WAIT_WRITE,
        WAIT_INSTRUCTION,
        MEM_READ,
        MEM_WRITE,
        INSTRUCTION_READ
    } req_state_t;

    typedef enum logic [1:0] {
        WBM_IDLE,
        WBM_CYCLE,
        WBM_DONE
    } wbm_state_t;

endpackage

`default_nettype wire

// File: request_unit.sv
`timescale 1ns/1ps
`default_nettype none

module request_unit (
    input  wire logic                 en_i,
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire memreq_pkg::cpu_req_t cpu_req_i,
    input  wire logic [31:0]          instruction_address_i,  // program counter
    input  wire logic                 busy_i,
    input  wire logic [31:0]          bus_rdata_i,
    output memreq_pkg::bus_cmd_t      cmd_o,
    output logic [31:0]               instruction_o,
    output logic [31:0]               data_read_o,
    output logic                      i_hit_o,
    output logic                      d_hit_o
);

    import memreq_pkg::*;

    req_state_t  state;
    req_state_t  next_state;
    bus_cmd_t    cmd_q;
    bus_cmd_t    next_cmd;
    logic [31:0] instr_q;
    logic [31:0] next_instr;
    logic [31:0] rdata_q;
    logic [31:0] next_rdata;
    logic        i_hit_q;
    logic        next_i_hit;
    logic        d_hit_q;
    logic        next_d_hit;
    logic        prev_busy;
    logic        busy_fell;

    // transfer is over once busy drops after having been high
    assign busy_fell = prev_busy && !busy_i;

    assign cmd_o         = cmd_q;
    assign instruction_o = instr_q;
    assign data_read_o   = rdata_q;
    assign i_hit_o       = i_hit_q;
    assign d_hit_o       = d_hit_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            cmd_q     <= '0;
            instr_q   <= '0;
            rdata_q   <= '0;
            i_hit_q   <= 1'b0;
            d_hit_q   <= 1'b0;
            prev_busy <= 1'b0;
        end else begin
            prev_busy <= busy_i;
            // hits are pulses, a stall must not stretch them
            i_hit_q   <= en_i && next_i_hit;
            d_hit_q   <= en_i && next_d_hit;
            if (en_i) begin
                state   <= next_state;
                cmd_q   <= next_cmd;
                instr_q <= next_instr;
                rdata_q <= next_rdata;
            end else begin
                cmd_q.read  <= 1'b0;  // nothing issued while stalled
                cmd_q.write <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state     = state;
        next_cmd       = cmd_q;        // adr/dat held until done
        next_cmd.read  = 1'b0;
        next_cmd.write = 1'b0;
        next_cmd.sel   = SEL_WORD;
        next_instr     = instr_q;
        next_rdata     = rdata_q;
        next_i_hit     = 1'b0;
        next_d_hit     = 1'b0;

        case (state)
            IDLE: begin
                // store over load over fetch
                if (cpu_req_i.memwrite && !d_hit_q) begin
                    next_state     = WAIT_WRITE;
                    next_cmd.write = 1'b1;
                    next_cmd.adr   = cpu_req_i.data_address + BUS_BASE;
                    next_cmd.dat   = cpu_req_i.data_to_write;
                end else if (cpu_req_i.memread && !d_hit_q) begin
                    next_state    = WAIT_READ;
                    next_cmd.read = 1'b1;
                    next_cmd.adr  = cpu_req_i.data_address + BUS_BASE;
                    next_cmd.dat  = '0;
                end else if (!i_hit_q) begin
                    next_state    = WAIT_INSTRUCTION;
                    next_cmd.read = 1'b1;
                    next_cmd.adr  = instruction_address_i + BUS_BASE;
                    next_cmd.dat  = '0;
                end
            end

            // manager picks up the strobe during these
            WAIT_WRITE:       next_state = MEM_WRITE;
            WAIT_READ:        next_state = MEM_READ;
            WAIT_INSTRUCTION: next_state = INSTRUCTION_READ;

            MEM_WRITE: begin
                if (busy_fell) begin
                    next_state = IDLE;
                    next_d_hit = 1'b1;
                end
            end

            MEM_READ: begin
                if (busy_fell) begin
                    next_state = IDLE;
                    next_rdata = bus_rdata_i;
                    next_d_hit = 1'b1;
                end
            end

            INSTRUCTION_READ: begin
                if (busy_fell) begin
                    next_state = IDLE;
                    next_instr = bus_rdata_i;
                    next_i_hit = 1'b1;
                end
            end

            default: next_state = IDLE;
        endcase
    end

    // one strobe at a time, each gone the following cycle
    strobe_one_hot_pulse: assert property (
        @(posedge clk) disable iff (rst)
        (cmd_q.read || cmd_q.write)
            |-> !(cmd_q.read && cmd_q.write) ##1 !(cmd_q.read || cmd_q.write)
    );

    // en may only drop between transactions, else the fall of busy is lost
    stall_only_between: assert property (
        @(posedge clk) disable iff (rst)
        !en_i |-> (state == IDLE) && !busy_i
    );

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    import memreq_pkg::*;

    typedef enum logic [1:0] {TXN_NONE, TXN_FETCH, TXN_LOAD, TXN_STORE} txn_kind_t;
    typedef enum logic [1:0] {PH_LOADS, PH_PAIRS, PH_MIXED} phase_kind_t;

    localparam int LATENCY  = WAIT_STATES + 5;  // cycles from acceptance to hit
    localparam int N_FETCH  = 20;
    localparam int N_LOAD   = 16;
    localparam int N_PAIR   = 12;
    localparam int N_MIX    = 16;
    localparam int N_STALL  = 4;
    localparam int N_RESUME = 4;
    // every data access is paired with one fetch
    localparam int PLANNED  = N_FETCH + 2 * (N_LOAD + 2 * N_PAIR + N_MIX) + N_STALL + N_RESUME;
    localparam int TIMEOUT_CYCLES = 12 * PLANNED + 200;

    logic        clk;
    logic        rst;
    logic        en;
    cpu_req_t    req;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic [31:0] data_read;
    logic        i_hit;
    logic        d_hit;

    logic [31:0] seed = 32'd52;
    int unsigned cycle = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] model_mem [MEM_WORDS];

    // request unit activity as predicted from the cpu side
    txn_kind_t   txn = TXN_NONE;
    logic [31:0] txn_addr;
    logic [31:0] txn_data;
    int unsigned txn_start;
    logic        prev_i_hit = 1'b0;
    logic        prev_d_hit = 1'b0;
    logic        i_seen;
    logic        d_seen;
    logic        data_waiting = 1'b0;  // data request out and no d_hit yet
    logic        stalled = 1'b0;
    logic [31:0] snap_instr;
    logic [31:0] snap_data;
    int          fetches;
    int          datas;
    int          err_before;
    logic [31:0] pair_addr [N_PAIR];

    mem_subsys_top uut (
        .clk                   (clk),
        .rst                   (rst),
        .en_i                  (en),
        .cpu_req_i             (req),
        .instruction_address_i (pc),
        .instruction_o         (instruction),
        .data_read_o           (data_read),
        .i_hit_o               (i_hit),
        .d_hit_o               (d_hit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin : watchdog
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] random_word_addr();
        logic [31:0] r;
        r = next_random();
        return ((r >> 12) % 32'(MEM_WORDS)) << 2;  // word aligned inside the sram
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("t=%0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic start_txn(input txn_kind_t kind, input logic [31:0] addr,
                             input logic [31:0] data);
        txn       = kind;
        txn_addr  = addr;
        txn_data  = data;
        txn_start = cycle;
    endtask

    task automatic finish_fetch();
        check_true(txn == TXN_FETCH, "i_hit_o pulsed with no fetch outstanding");
        check_true(!data_waiting, "a fetch completed ahead of a pending data request");
        if (txn == TXN_FETCH) begin
            check_value("i_hit latency", 32'(cycle - txn_start), LATENCY);
            check_value("instruction_o", instruction, model_mem[txn_addr[MEM_AW+1:2]]);
            fetches++;
            txn = TXN_NONE;
        end
    endtask

    task automatic finish_data();
        check_true(txn == TXN_LOAD || txn == TXN_STORE,
                   "d_hit_o pulsed with no load or store outstanding");
        if (txn == TXN_LOAD || txn == TXN_STORE) begin
            check_value("d_hit latency", 32'(cycle - txn_start), LATENCY);
            if (txn == TXN_LOAD) begin
                check_value("data_read_o", data_read, model_mem[txn_addr[MEM_AW+1:2]]);
            end else begin
                model_mem[txn_addr[MEM_AW+1:2]] = txn_data;  // store has landed
            end
            datas++;
            data_waiting = 1'b0;
            txn = TXN_NONE;
        end
    endtask

    // check outputs on the falling edge and predict what the next edge accepts
    task automatic sample_cycle();
        @(negedge clk);
        i_seen = i_hit;
        d_seen = d_hit;
        check_true(!(i_hit && d_hit), "i_hit_o and d_hit_o pulsed in the same cycle");
        check_true(!(i_hit && prev_i_hit), "i_hit_o stayed high for more than one cycle");
        check_true(!(d_hit && prev_d_hit), "d_hit_o stayed high for more than one cycle");
        if (stalled) begin
            check_true(!i_hit && !d_hit, "hit pulse while en_i was low");
            check_value("instruction_o", instruction, snap_instr);
            check_value("data_read_o", data_read, snap_data);
        end
        if (i_hit) finish_fetch();
        if (d_hit) finish_data();
        prev_i_hit = i_hit;
        prev_d_hit = d_hit;
        if (txn == TXN_NONE && en) begin
            // store before load before fetch and a hit blocks its own kind once
            if (req.memwrite && !d_hit) begin
                start_txn(TXN_STORE, req.data_address, req.data_to_write);
            end else if (req.memread && !d_hit) begin
                start_txn(TXN_LOAD, req.data_address, 32'h0);
            end else if (!i_hit) begin
                start_txn(TXN_FETCH, pc, 32'h0);
            end
        end
    endtask

    // cpu reacts to hits just after the rising edge
    task automatic run_cycle();
        sample_cycle();
        @(posedge clk);
        #1;
        if (d_seen) req = '0;
        if (i_seen) pc = random_word_addr();
    endtask

    task automatic issue_data(input logic write, input logic [31:0] addr,
                              input logic [31:0] data);
        req.memread       = !write;
        req.memwrite      = write;
        req.data_address  = addr;
        req.data_to_write = write ? data : 32'h0;
        data_waiting      = 1'b1;
    endtask

    // data requests go out right after an i_hit so a fetch is pending too
    task automatic run_data_phase(input phase_kind_t kind, input int count);
        int          issued;
        logic [31:0] r;
        issued = 0;
        datas  = 0;
        while (datas < count) begin
            run_cycle();
            if (i_seen && !(req.memread || req.memwrite) && issued < count) begin
                case (kind)
                    PH_LOADS: issue_data(1'b0, random_word_addr(), 32'h0);
                    PH_PAIRS: begin
                        if (issued < N_PAIR) begin
                            issue_data(1'b1, pair_addr[issued], next_random());
                        end else begin
                            issue_data(1'b0, pair_addr[issued - N_PAIR], 32'h0);
                        end
                    end
                    default: begin
                        r = next_random();
                        issue_data(r[20], random_word_addr(), next_random());
                    end
                endcase
                issued++;
            end
        end
    endtask

    initial begin
        int base;
        int len;
        rst = 1'b1;
        en  = 1'b1;
        req = '0;
        pc  = 32'h0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = 32'(i) * 32'h0101_0101;  // sram reset pattern
        end
        err_before = errors;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_true(!i_hit && !d_hit, "hit pulse during reset");
        check_value("instruction_o", instruction, 32'h0);
        check_value("data_read_o", data_read, 32'h0);
        @(posedge clk);
        #1;
        rst = 1'b0;

        fetches = 0;
        while (fetches < N_FETCH) run_cycle();
        $display("test 1 fetch stream: %0d fetches, %0d errors", fetches, errors - err_before);

        err_before = errors;
        run_data_phase(PH_LOADS, N_LOAD);
        $display("test 2 random loads: %0d loads, %0d errors", datas, errors - err_before);

        err_before = errors;
        base = int'(next_random() >> 16) % MEM_WORDS;
        for (int i = 0; i < N_PAIR; i++) begin
            pair_addr[i] = 32'((base + i * 37) % MEM_WORDS) << 2;  // distinct words
        end
        run_data_phase(PH_PAIRS, 2 * N_PAIR);
        $display("test 3 store then load: %0d accesses, %0d errors", datas,
                 errors - err_before);

        err_before = errors;
        run_data_phase(PH_MIXED, N_MIX);
        $display("test 4 priority over fetch: %0d accesses, %0d errors", datas,
                 errors - err_before);

        err_before = errors;
        fetches = 0;
        for (int s = 0; s < N_STALL; s++) begin
            do run_cycle(); while (!i_seen);
            en         = 1'b0;  // unit idle with its fetch blocked by the hit
            stalled    = 1'b1;
            snap_instr = instruction;
            snap_data  = data_read;
            len = 3 + int'((next_random() >> 20) % 4);
            repeat (len) run_cycle();
            en      = 1'b1;
            stalled = 1'b0;
        end
        while (fetches < N_STALL + N_RESUME) run_cycle();
        $display("test 5 stall and resume: %0d stalls, %0d errors", N_STALL,
                 errors - err_before);

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_manager.sv
`timescale 1ns/1ps
`default_nettype none

module wb_manager (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire memreq_pkg::bus_cmd_t cmd_i,
    output logic                      busy_o,
    output logic [31:0]               rdata_o,
    output memreq_pkg::wb_m2s_t       wb_o,
    input  wire memreq_pkg::wb_s2m_t  wb_i
);

    import memreq_pkg::*;

    wbm_state_t  state;
    wb_m2s_t     wb_q;
    logic [31:0] rdata_q;
    logic        cmd_strobe;

    assign cmd_strobe = cmd_i.read || cmd_i.write;

    assign wb_o    = wb_q;
    assign rdata_o = rdata_q;
    assign busy_o  = (state == WBM_CYCLE);  // high exactly while cyc is open

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= WBM_IDLE;
            wb_q    <= '0;
            rdata_q <= '0;
        end else begin
            case (state)
                WBM_IDLE: begin
                    if (cmd_strobe) begin
                        wb_q.cyc <= 1'b1;
                        wb_q.stb <= 1'b1;
                        wb_q.we  <= cmd_i.write;
                        wb_q.adr <= cmd_i.adr;
                        wb_q.dat <= cmd_i.dat;
                        wb_q.sel <= cmd_i.sel;
                        state    <= WBM_CYCLE;
                    end
                end

                WBM_CYCLE: begin
                    // classic cycle, close on the edge after ack
                    if (wb_i.ack) begin
                        rdata_q  <= wb_i.dat;
                        wb_q.cyc <= 1'b0;
                        wb_q.stb <= 1'b0;
                        wb_q.we  <= 1'b0;
                        state    <= WBM_DONE;
                    end
                end

                WBM_DONE: state <= WBM_IDLE;  // one dead cycle between cycles

                default: state <= WBM_IDLE;
            endcase
        end
    end

    // a new command only lands in idle and always opens a cycle
    strobe_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        cmd_strobe |-> (state == WBM_IDLE) ##1 busy_o
    );

    // slave acks only inside an open cycle, which then closes
    ack_inside_cycle: assert property (
        @(posedge clk) disable iff (rst)
        wb_i.ack |-> (wb_q.cyc && wb_q.stb) ##1 !wb_q.cyc
    );

endmodule

`default_nettype wire

// File: wb_sram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sram (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire memreq_pkg::wb_m2s_t wb_i,
    output memreq_pkg::wb_s2m_t      wb_o
);

    import memreq_pkg::*;

    logic [31:0]        mem [MEM_WORDS];
    logic [31:0]        offset;
    logic [MEM_AW-1:0]  idx;
    logic [WAIT_CW-1:0] wait_cnt;
    wb_s2m_t            s2m_q;
    logic               selected;
    logic               access;

    // strip the bus window, then word index
    assign offset   = wb_i.adr - BUS_BASE;
    assign idx      = offset[MEM_AW+1:2];
    assign selected = wb_i.cyc && wb_i.stb;
    assign access   = selected && !s2m_q.ack;  // no second ack in the same cycle

    assign wb_o = s2m_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
            s2m_q    <= '0;
            // known pattern, word n holds n in every byte
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= 32'(i) * 32'h0101_0101;
            end
        end else begin
            s2m_q.ack <= 1'b0;
            if (access) begin
                if (wait_cnt == WAIT_CW'(WAIT_STATES)) begin
                    wait_cnt  <= '0;
                    s2m_q.ack <= 1'b1;
                    s2m_q.dat <= mem[idx];
                    if (wb_i.we) begin
                        mem[idx] <= wb_i.dat;  // sel is always full word
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end else if (!selected) begin
                wait_cnt <= '0;  // cycle abandoned
            end
        end
    end

endmodule

`default_nettype wire
